// File: common/vga_pkg.sv
package vga_pkg;

    typedef logic [10:0] coord_t;                       // pixel column or line number

    // 800x600 at 60 Hz with a 40 MHz pixel clock
    localparam coord_t HOR_PIXELS     = 11'd800;        // visible pixels per line
    localparam coord_t HOR_TOTAL      = 11'd1056;       // clocks per line
    localparam coord_t HOR_SYNC_START = 11'd840;        // first hsync clock
    localparam coord_t HOR_SYNC_STOP  = 11'd967;        // last hsync clock

    localparam coord_t VER_PIXELS     = 11'd600;        // visible lines per frame
    localparam coord_t VER_TOTAL      = 11'd628;        // lines per frame
    localparam coord_t VER_SYNC_START = 11'd601;        // first vsync line
    localparam coord_t VER_SYNC_STOP  = 11'd604;        // last vsync line

endpackage

// File: common/draw_pkg.sv
package draw_pkg;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    localparam rgb_t COL_BLACK  = 12'h000;
    localparam rgb_t COL_YELLOW = 12'hff0;
    localparam rgb_t COL_RED    = 12'hf00;
    localparam rgb_t COL_GREEN  = 12'h0f0;
    localparam rgb_t COL_BLUE   = 12'h00f;
    localparam rgb_t COL_GRAY   = 12'h888;

    // one pixel slot of the video pipeline
    typedef struct packed {
        vga_pkg::coord_t vcount;
        logic            vsync;
        logic            vblnk;
        vga_pkg::coord_t hcount;
        logic            hsync;
        logic            hblnk;
        rgb_t            rgb;
    } vga_bus_t;

endpackage

// File: src/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic               clk,
    input  logic               rst,
    output draw_pkg::vga_bus_t bus
);

    import vga_pkg::*;
    import draw_pkg::*;

    coord_t   hcount_nxt;
    coord_t   vcount_nxt;
    vga_bus_t bus_nxt;

    always_comb begin
        if (bus.hcount == HOR_TOTAL - 11'd1) begin         // end of line
            hcount_nxt = '0;
            if (bus.vcount == VER_TOTAL - 11'd1) begin     // end of frame
                vcount_nxt = '0;
            end else begin
                vcount_nxt = bus.vcount + 11'd1;
            end
        end else begin
            hcount_nxt = bus.hcount + 11'd1;
            vcount_nxt = bus.vcount;
        end
    end

    // syncs and blanks come from the next counts so a word stays consistent
    always_comb begin
        bus_nxt.hcount = hcount_nxt;
        bus_nxt.vcount = vcount_nxt;
        bus_nxt.hblnk  = (hcount_nxt >= HOR_PIXELS);
        bus_nxt.vblnk  = (vcount_nxt >= VER_PIXELS);
        bus_nxt.hsync  = (hcount_nxt >= HOR_SYNC_START) && (hcount_nxt <= HOR_SYNC_STOP);
        bus_nxt.vsync  = (vcount_nxt >= VER_SYNC_START) && (vcount_nxt <= VER_SYNC_STOP);
        bus_nxt.rgb    = COL_BLACK;                        // colour is added downstream
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus <= '0;                                     // pixel 0,0 with all levels low
        end else begin
            bus <= bus_nxt;
        end
    end

endmodule

// File: draw/draw_bg.sv
`timescale 1ns/1ps

module draw_bg (
    input  logic               clk,
    input  logic               rst,
    input  draw_pkg::vga_bus_t bus_in,
    output draw_pkg::vga_bus_t bus_out
);

    import vga_pkg::*;
    import draw_pkg::*;

    int       hc;
    int       vc;
    logic     letter_on;
    rgb_t     rgb_nxt;
    vga_bus_t bus_nxt;

    function automatic logic in_range(input int x, input int lo, input int hi);
        return (x >= lo) && (x <= hi);
    endfunction

    // M from two bars and two diagonal bands
    function automatic logic m_shape(input int h, input int v);
        return (in_range(h, 50, 100) && in_range(v, 10, 425)) ||
               (in_range(h, 240, 290) && in_range(v, 10, 425)) ||
               (in_range(h, 100, 170) && in_range(h - v, 0, 90)) ||
               (in_range(h, 170, 240) && in_range(h + v, 250, 340));
    endfunction

    // S from three flat bars joined by slanted bands
    function automatic logic s_shape(input int h, input int v);
        return (in_range(h, 350, 430) && in_range(h + v, 440, 490)) ||
               (in_range(h, 510, 590) && in_range(h - v, 450, 500)) ||
               (in_range(h, 430, 510) && in_range(v, 10, 60)) ||
               (in_range(h, 350, 430) && in_range(h - v, 195, 245)) ||
               (in_range(h, 430, 510) && in_range(v, 185, 235)) ||
               (in_range(h, 510, 590) && in_range(h - v, 275, 325)) ||
               (in_range(h, 510, 590) && in_range(h + v, 885, 935)) ||
               (in_range(h, 430, 510) && in_range(v, 375, 425)) ||
               (in_range(h, 350, 430) && in_range(h - v, 5, 55));
    endfunction

    assign hc        = int'(bus_in.hcount);
    assign vc        = int'(bus_in.vcount);
    assign letter_on = m_shape(hc, vc) || s_shape(hc, vc);

    always_comb begin
        if (bus_in.vblnk || bus_in.hblnk) begin
            rgb_nxt = COL_BLACK;                           // no colour in blanking
        end else if (bus_in.vcount == 11'd0) begin
            rgb_nxt = COL_YELLOW;                          // top line
        end else if (bus_in.vcount == VER_PIXELS - 11'd1) begin
            rgb_nxt = COL_RED;                             // bottom line
        end else if (bus_in.hcount == 11'd0) begin
            rgb_nxt = COL_GREEN;                           // left column
        end else if (bus_in.hcount == HOR_PIXELS - 11'd1) begin
            rgb_nxt = COL_BLUE;                            // right column
        end else if (letter_on) begin
            rgb_nxt = COL_GREEN;
        end else begin
            rgb_nxt = COL_GRAY;                            // fill
        end
    end

    always_comb begin
        bus_nxt     = bus_in;
        bus_nxt.rgb = rgb_nxt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
        end else begin
            bus_out <= bus_nxt;
        end
    end

endmodule

// File: draw/draw_rect.sv
`timescale 1ns/1ps

module draw_rect #(
    parameter int             RECT_W     = 64,
    parameter int             RECT_H     = 48,
    parameter draw_pkg::rgb_t RECT_COLOR = draw_pkg::COL_BLUE
) (
    input  logic               clk,
    input  logic               rst,
    input  draw_pkg::vga_bus_t bus_in,
    output draw_pkg::vga_bus_t bus_out,
    input  vga_pkg::coord_t    rect_x,
    input  vga_pkg::coord_t    rect_y
);

    import vga_pkg::*;
    import draw_pkg::*;

    coord_t   x_last;                                      // rightmost column of block
    coord_t   y_last;                                      // lowest line of block
    logic     in_rect;
    vga_bus_t bus_nxt;

    assign x_last  = rect_x + coord_t'(RECT_W - 1);
    assign y_last  = rect_y + coord_t'(RECT_H - 1);
    assign in_rect = (bus_in.hcount >= rect_x) && (bus_in.hcount <= x_last) &&
                     (bus_in.vcount >= rect_y) && (bus_in.vcount <= y_last);

    always_comb begin
        bus_nxt = bus_in;
        if (!bus_in.hblnk && !bus_in.vblnk && in_rect) begin
            bus_nxt.rgb = RECT_COLOR;                      // block covers background
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
        end else begin
            bus_out <= bus_nxt;
        end
    end

endmodule

// File: src/rect_ctl.sv
`timescale 1ns/1ps

module rect_ctl #(
    parameter int RECT_W  = 64,
    parameter int RECT_H  = 48,
    parameter int STEP    = 8,
    parameter int START_X = 300,
    parameter int START_Y = 200
) (
    input  logic               clk,
    input  logic               rst,
    input  draw_pkg::vga_bus_t bus_in,
    input  logic               move,
    output vga_pkg::coord_t    rect_x,
    output vga_pkg::coord_t    rect_y
);

    import vga_pkg::*;

    // box kept clear of the border lines
    localparam int X_MIN = 1;
    localparam int X_MAX = int'(HOR_PIXELS) - RECT_W - 1;
    localparam int Y_MIN = 1;
    localparam int Y_MAX = int'(VER_PIXELS) - RECT_H - 1;

    logic vblnk_prev;
    logic frame_start;
    logic x_back;                                          // moving left
    logic y_back;                                          // moving up
    int   x_cand;
    int   y_cand;

    assign frame_start = bus_in.vblnk && !vblnk_prev;      // first blank line of frame
    assign x_cand = x_back ? int'(rect_x) - STEP : int'(rect_x) + STEP;
    assign y_cand = y_back ? int'(rect_y) - STEP : int'(rect_y) + STEP;

    always_ff @(posedge clk) begin
        if (rst) begin
            vblnk_prev <= 1'b0;
            x_back     <= 1'b0;
            y_back     <= 1'b0;
            rect_x     <= coord_t'(START_X);
            rect_y     <= coord_t'(START_Y);
        end else begin
            vblnk_prev <= bus_in.vblnk;
            if (frame_start && move) begin
                if ((x_cand < X_MIN) || (x_cand > X_MAX)) begin
                    x_back <= !x_back;                     // bounce, hold this frame
                end else begin
                    rect_x <= coord_t'(x_cand);
                end
                if ((y_cand < Y_MIN) || (y_cand > Y_MAX)) begin
                    y_back <= !y_back;
                end else begin
                    rect_y <= coord_t'(y_cand);
                end
            end
        end
    end

endmodule

// File: src/vga_top.sv
`timescale 1ns/1ps

module vga_top #(
    parameter int             RECT_W     = 64,
    parameter int             RECT_H     = 48,
    parameter int             STEP       = 8,
    parameter int             START_X    = 300,
    parameter int             START_Y    = 200,
    parameter draw_pkg::rgb_t RECT_COLOR = draw_pkg::COL_BLUE
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               move,
    output draw_pkg::vga_bus_t vga
);

    import vga_pkg::*;
    import draw_pkg::*;

    vga_bus_t bus_tim;                                     // raw timing
    vga_bus_t bus_bg;                                      // background painted
    coord_t   rect_x;
    coord_t   rect_y;

    vga_timing u_vga_timing (
        .clk (clk),
        .rst (rst),
        .bus (bus_tim)
    );

    draw_bg u_draw_bg (
        .clk     (clk),
        .rst     (rst),
        .bus_in  (bus_tim),
        .bus_out (bus_bg)
    );

    rect_ctl #(
        .RECT_W  (RECT_W),
        .RECT_H  (RECT_H),
        .STEP    (STEP),
        .START_X (START_X),
        .START_Y (START_Y)
    ) u_rect_ctl (
        .clk    (clk),
        .rst    (rst),
        .bus_in (bus_tim),
        .move   (move),
        .rect_x (rect_x),
        .rect_y (rect_y)
    );

    draw_rect #(
        .RECT_W     (RECT_W),
        .RECT_H     (RECT_H),
        .RECT_COLOR (RECT_COLOR)
    ) u_draw_rect (
        .clk     (clk),
        .rst     (rst),
        .bus_in  (bus_bg),
        .bus_out (vga),
        .rect_x  (rect_x),
        .rect_y  (rect_y)
    );

endmodule

// File: tb/vga_assert.sv
`timescale 1ns/1ps

module vga_assert #(
    parameter int             RECT_W     = 64,
    parameter int             RECT_H     = 48,
    parameter int             STEP       = 8,
    parameter draw_pkg::rgb_t RECT_COLOR = draw_pkg::COL_BLUE
) (
    input logic               clk,
    input logic               rst,
    input logic               move,
    input draw_pkg::vga_bus_t bus_tim,
    input draw_pkg::vga_bus_t vga,
    input vga_pkg::coord_t    rect_x,
    input vga_pkg::coord_t    rect_y
);

    import vga_pkg::*;
    import draw_pkg::*;

    localparam coord_t W      = coord_t'(RECT_W);
    localparam coord_t H      = coord_t'(RECT_H);
    localparam coord_t STEP_C = coord_t'(STEP);

    bit         failed = 1'b0;                             // sticky, seen by the testbench
    logic [2:0] age;                                       // clocks since reset, saturates
    logic       live;
    coord_t     x_prev;                                    // position draw_rect used
    coord_t     y_prev;
    logic       in_block;
    logic       exp_valid;
    rgb_t       exp_rgb;

    always_ff @(posedge clk) begin
        if (rst) begin
            age <= '0;
        end else if (age != 3'd7) begin
            age <= age + 3'd1;
        end
        x_prev <= rect_x;
        y_prev <= rect_y;
    end

    assign live     = (age == 3'd7);                       // pipeline filled with real words
    assign in_block = (vga.hcount >= x_prev) && (vga.hcount < x_prev + W) &&
                      (vga.vcount >= y_prev) && (vga.vcount < y_prev + H);

    // colour the screen layout fixes for this pixel
    always_comb begin
        exp_valid = 1'b1;
        exp_rgb   = COL_GRAY;
        if (vga.hblnk || vga.vblnk) begin
            exp_rgb = COL_BLACK;
        end else if (vga.vcount == 11'd0) begin
            exp_rgb = COL_YELLOW;
        end else if (vga.vcount == VER_PIXELS - 11'd1) begin
            exp_rgb = COL_RED;
        end else if (vga.hcount == 11'd0) begin
            exp_rgb = COL_GREEN;
        end else if (vga.hcount == HOR_PIXELS - 11'd1) begin
            exp_rgb = COL_BLUE;
        end else if (in_block) begin
            exp_rgb = RECT_COLOR;
        end else if ((vga.hcount >= 11'd50) && (vga.hcount <= 11'd100) &&
                     (vga.vcount >= 11'd10) && (vga.vcount <= 11'd425)) begin
            exp_rgb = COL_GREEN;                           // left bar of the M
        end else if ((vga.hcount != 11'd700) || (vga.vcount != 11'd500)) begin
            exp_valid = 1'b0;                              // only the gray probe point left
        end
    end

    assert property (@(posedge clk) disable iff (!live)
        (vga.hsync == ((vga.hcount >= HOR_SYNC_START) && (vga.hcount <= HOR_SYNC_STOP))) &&
        (vga.vsync == ((vga.vcount >= VER_SYNC_START) && (vga.vcount <= VER_SYNC_STOP))) &&
        (vga.hblnk == (vga.hcount >= HOR_PIXELS)) && (vga.vblnk == (vga.vcount >= VER_PIXELS)))
        else begin
            $error("** Error vga.hsync/vsync/hblnk/vblnk is %h/%h/%h/%h at hcount %h vcount %h",
                   $sampled(vga.hsync), $sampled(vga.vsync),
                   $sampled(vga.hblnk), $sampled(vga.vblnk),
                   $sampled(vga.hcount), $sampled(vga.vcount));
            failed = 1'b1;
        end

    assert property (@(posedge clk) disable iff (!live)
        ($past(vga.hcount) == HOR_TOTAL - 11'd1) ?
            ((vga.hcount == 11'd0) && (vga.vcount == (($past(vga.vcount) == VER_TOTAL - 11'd1) ?
                                                      11'd0 : $past(vga.vcount) + 11'd1))) :
            ((vga.hcount == $past(vga.hcount) + 11'd1) && (vga.vcount == $past(vga.vcount))))
        else begin
            $error("** Error vga.hcount/vcount is %h/%h after %h/%h",
                   $sampled(vga.hcount), $sampled(vga.vcount),
                   $past(vga.hcount), $past(vga.vcount));
            failed = 1'b1;
        end

    assert property (@(posedge clk) disable iff (!live)
        exp_valid |-> (vga.rgb == exp_rgb))
        else begin
            $error("** Error vga.rgb is %h, expected %h at hcount %h vcount %h",
                   $sampled(vga.rgb), $sampled(exp_rgb),
                   $sampled(vga.hcount), $sampled(vga.vcount));
            failed = 1'b1;
        end

    assert property (@(posedge clk) disable iff (!live)
        ((rect_x != $past(rect_x)) || (rect_y != $past(rect_y))) |->
            ($past(move) && $past(bus_tim.vblnk) && !$past(bus_tim.vblnk, 2)))
        else begin
            $error("rectangle moved away from the start of vertical blanking or with move low");
            failed = 1'b1;
        end

    assert property (@(posedge clk) disable iff (!live)
        ((rect_x == $past(rect_x)) || (rect_x == $past(rect_x) + STEP_C) ||
         (rect_x == $past(rect_x) - STEP_C)) &&
        ((rect_y == $past(rect_y)) || (rect_y == $past(rect_y) + STEP_C) ||
         (rect_y == $past(rect_y) - STEP_C)) &&
        (rect_x >= 11'd1) && (rect_x <= HOR_PIXELS - W - 11'd1) &&
        (rect_y >= 11'd1) && (rect_y <= VER_PIXELS - H - 11'd1))
        else begin
            $error("** Error rect_x/rect_y is %h/%h after %h/%h",
                   $sampled(rect_x), $sampled(rect_y), $past(rect_x), $past(rect_y));
            failed = 1'b1;
        end

endmodule

bind vga_top vga_assert #(
    .RECT_W     (RECT_W),
    .RECT_H     (RECT_H),
    .STEP       (STEP),
    .RECT_COLOR (RECT_COLOR)
) u_vga_assert (.*);

// File: tb/vga_tb.sv
`timescale 1ns/1ps

module vga_tb;

    import draw_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES   = 2_200_000;               // three frames of 663168 plus margin

    logic     clk;
    logic     rst;
    logic     move;
    vga_bus_t vga;
    int       cycles = 0;

    vga_top u_vga_top (
        .clk  (clk),
        .rst  (rst),
        .move (move),
        .vga  (vga)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    // returns once the output enters vertical blanking
    task automatic wait_frame_end();
        @(negedge clk);
        while (vga.vblnk) begin
            @(negedge clk);
        end
        while (!vga.vblnk) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles before the last frame ended", cycles));
        end
    end

    always @(negedge clk) begin
        if (u_vga_top.u_vga_assert.failed) begin
            abort_run("an assertion on the DUT output failed");
        end
    end

    initial begin
        rst  = 1'b1;
        move = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        wait_frame_end();                                  // first frame with a still block
        @(posedge clk);
        move <= 1'b1;
        repeat (2) wait_frame_end();
        @(negedge clk);
        if (u_vga_top.u_vga_assert.failed) begin
            abort_run("an assertion failed in the last frame");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: list.f
common/vga_pkg.sv
common/draw_pkg.sv
src/vga_timing.sv
draw/draw_bg.sv
draw/draw_rect.sv
src/rect_ctl.sv
src/vga_top.sv
tb/vga_assert.sv
tb/vga_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = vga_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = === PASS ===

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
